/* hw/aes_config.svh */
`ifndef AES_CONFIG_SVH
`define AES_CONFIG_SVH

// Key length in bits
`define AES_KEY_BITS 128
// Rounds for a 128-bit key
`define AES_ROUNDS 10
// Byte address width of the register window
`define AES_ADDR_BITS 6

// Word 0 of each block holds its top 32 bits
`define AES_KEY_BASE 6'h00
`define AES_DIN_BASE 6'h10
`define AES_DOUT_BASE 6'h20
`define AES_CTRL 6'h30
`define AES_STAT 6'h34

`endif

/* hw/aesTypesPkg.sv */
package aesTypesPkg;

  // One byte of cipher state
  typedef logic [7:0] byteT;

  // Column word with row 0 in the top byte
  typedef byteT [0:3] colT;

  // Cipher state
  // AES byte n sits at bytes[n] and column c at cols[c]
  typedef union packed {
    byteT [0:15] bytes;
    colT [0:3] cols;
  } blockT;

  // Product in GF(2^8) modulo x^8 + x^4 + x^3 + x + 1
  function automatic byteT gfMul(byteT a, byteT b);
    byteT acc;
    byteT sh;
    acc = '0;
    sh = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        acc = acc ^ sh;
      end
      // Double and reduce
      sh = {sh[6:0], 1'b0} ^ (sh[7] ? 8'h1b : 8'h00);
    end
    return acc;
  endfunction

endpackage

/* hw/aesRegsPkg.sv */
`include "aes_config.svh"

package aesRegsPkg;

  // Byte address on the AXI4-Lite port
  typedef logic [`AES_ADDR_BITS-1:0] addrT;

  // Cipher direction
  typedef enum logic {
    opEncrypt = 1'b0,
    opDecrypt = 1'b1
  } aesOpT;

  // Control word
  typedef struct packed {
    logic [29:0] rsvd;
    aesOpT op;
    logic start;
  } ctrlT;

  // Status word
  typedef struct packed {
    logic [29:0] rsvd;
    logic done;
    logic busy;
  } statT;

  // Decoded register group
  typedef enum logic [2:0] {
    selKey, selDin, selDout, selCtrl, selStat, selNone
  } regSelT;

endpackage

/* hw/aesSbox.sv */
`timescale 1ns/100ps

module aesSbox import aesTypesPkg::*; (
  input  byteT inByte,
  input  logic inverse,
  output byteT outByte
);

  // Operand of the field inverse
  byteT invIn;
  // Powers of invIn on the way to invIn^254
  byteT p2, p3, p6, p12, p15, p30, p60, p120, p240, p252, p254;

  // Byte rotate left
  function automatic byteT rotl(byteT v, int unsigned n);
    return (v << n) | (v >> (8 - n));
  endfunction

  // Inverse box undoes the affine map before inverting
  assign invIn = inverse ?
                 (rotl(inByte, 1) ^ rotl(inByte, 3) ^ rotl(inByte, 6) ^ 8'h05) :
                 inByte;

  // a^254 equals a^-1 in GF(2^8) and maps zero to zero
  assign p2   = gfMul(invIn, invIn);
  assign p3   = gfMul(p2, invIn);
  assign p6   = gfMul(p3, p3);
  assign p12  = gfMul(p6, p6);
  assign p15  = gfMul(p12, p3);
  assign p30  = gfMul(p15, p15);
  assign p60  = gfMul(p30, p30);
  assign p120 = gfMul(p60, p60);
  assign p240 = gfMul(p120, p120);
  // 240 + 12 then + 2
  assign p252 = gfMul(p240, p12);
  assign p254 = gfMul(p252, p2);

  // Forward box applies the affine map after the inverse
  assign outByte = inverse ? p254 :
                   (p254 ^ rotl(p254, 1) ^ rotl(p254, 2) ^ rotl(p254, 3) ^
                    rotl(p254, 4) ^ 8'h63);

endmodule

/* hw/keyExpand.sv */
`timescale 1ns/100ps
`include "aes_config.svh"

module keyExpand import aesTypesPkg::*; import aesRegsPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     load,
  input  logic                     step,
  input  aesOpT                    op,
  input  logic [`AES_KEY_BITS-1:0] key,
  output blockT                    roundKey,
  output logic                     ready
);

  // Last count of the forward run ahead of a decrypt
  localparam logic [3:0] lastStep = 4'(`AES_ROUNDS - 1);

  typedef enum logic [1:0] {kIdle, kPrerun, kReady} keyStateT;

  keyStateT   kState;
  aesOpT      opReg;
  logic [3:0] stepCnt;
  // Current round key
  blockT      rk;
  blockT      rkNext;
  // Constant that produced the current round key
  byteT       rcon;
  byteT       rconUse;
  logic       advance;
  logic       backward;
  colT        lastWord;
  colT        rotWord;
  colT        subWord;
  colT        mixWord;

  // Constant divided by x in GF(2^8)
  function automatic byteT halve(byteT v);
    return v[0] ? (((v ^ 8'h1b) >> 1) | 8'h80) : (v >> 1);
  endfunction

  // Decrypt walks back once the forward run has ended
  assign backward = (kState == kReady) && (opReg == opDecrypt);
  assign advance  = (kState == kPrerun) || ((kState == kReady) && step);

  // Forward uses the next constant
  // backward uses the one stored with the key
  assign rconUse = backward ? rcon : gfMul(rcon, 8'h02);

  // Old last word comes back as the XOR of the two newest words
  assign lastWord = backward ? (rk.cols[3] ^ rk.cols[2]) : rk.cols[3];
  // RotWord
  assign rotWord  = {lastWord[1], lastWord[2], lastWord[3], lastWord[0]};

  // SubWord
  for (genvar i = 0; i < 4; i++) begin : gSub
    aesSbox i_sbox (
      .inByte  (rotWord[i]),
      .inverse (1'b0),
      .outByte (subWord[i])
    );
  end

  // Constant lands on the top byte only
  assign mixWord = subWord ^ {rconUse, 24'h000000};

  always_comb begin
    if (backward) begin
      // Undo the chained XORs from the top word down
      rkNext.cols[3] = rk.cols[3] ^ rk.cols[2];
      rkNext.cols[2] = rk.cols[2] ^ rk.cols[1];
      rkNext.cols[1] = rk.cols[1] ^ rk.cols[0];
      rkNext.cols[0] = rk.cols[0] ^ mixWord;
    end else begin
      // Each word folds in the new word before it
      rkNext.cols[0] = rk.cols[0] ^ mixWord;
      rkNext.cols[1] = rk.cols[1] ^ rkNext.cols[0];
      rkNext.cols[2] = rk.cols[2] ^ rkNext.cols[1];
      rkNext.cols[3] = rk.cols[3] ^ rkNext.cols[2];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      kState  <= kIdle;
      opReg   <= opEncrypt;
      stepCnt <= '0;
      rk      <= '0;
      rcon    <= '0;
    end else if (load) begin
      rk      <= key;
      // x^-1 so that the first doubling gives 0x01
      rcon    <= 8'h8d;
      opReg   <= op;
      stepCnt <= '0;
      kState  <= (op == opDecrypt) ? kPrerun : kReady;
    end else if (advance) begin
      rk   <= rkNext;
      rcon <= backward ? halve(rcon) : rconUse;
      if (kState == kPrerun) begin
        stepCnt <= stepCnt + 4'd1;
        // Park on the last round key
        if (stepCnt == lastStep) begin
          kState <= kReady;
        end
      end
    end
  end

  assign roundKey = rk;
  assign ready    = (kState == kReady);

endmodule

/* hw/aesRound.sv */
`timescale 1ns/100ps
`include "aes_config.svh"

module aesRound import aesTypesPkg::*; import aesRegsPkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  aesOpT op,
  input  blockT dataIn,
  input  blockT roundKey,
  input  logic  keyReady,
  output logic  keyLoad,
  output logic  keyStep,
  output logic  busy,
  output logic  done,
  output blockT dataOut
);

  typedef enum logic [1:0] {sIdle, sInit, sRound} roundStateT;

  roundStateT  state;
  // Round in progress, 1 to AES_ROUNDS
  logic [3:0]  round;
  aesOpT       opReg;
  logic        decrypt;
  logic        lastRound;
  // Cipher state
  blockT       blk;
  byteT [0:15] subOut;
  blockT       shifted;
  blockT       roundOut;

  // MixColumns on one column
  // inv selects the InvMixColumns matrix
  function automatic colT mixCol(colT a, logic inv);
    byteT m0, m1, m2, m3;
    colT  r;
    m0 = inv ? 8'h0e : 8'h02;
    m1 = inv ? 8'h0b : 8'h03;
    m2 = inv ? 8'h0d : 8'h01;
    m3 = inv ? 8'h09 : 8'h01;
    for (int i = 0; i < 4; i++) begin
      r[i] = gfMul(a[i], m0) ^ gfMul(a[(i + 1) % 4], m1) ^
             gfMul(a[(i + 2) % 4], m2) ^ gfMul(a[(i + 3) % 4], m3);
    end
    return r;
  endfunction

  assign decrypt   = (opReg == opDecrypt);
  assign lastRound = (round == 4'(`AES_ROUNDS));

  // SubBytes or InvSubBytes
  for (genvar i = 0; i < 16; i++) begin : gSub
    aesSbox i_sbox (
      .inByte  (blk.bytes[i]),
      .inverse (decrypt),
      .outByte (subOut[i])
    );
  end

  // ShiftRows rotates row r left by r
  // the inverse rotates it right
  always_comb begin
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shifted.bytes[4 * c + r] = decrypt ? subOut[4 * ((c + 4 - r) % 4) + r] :
                                             subOut[4 * ((c + r) % 4) + r];
      end
    end
  end

  always_comb begin
    colT keyed;
    colT mixed;
    keyed = '0;
    mixed = '0;
    for (int c = 0; c < 4; c++) begin
      if (decrypt) begin
        // Key first and then InvMixColumns
        keyed = shifted.cols[c] ^ roundKey.cols[c];
        roundOut.cols[c] = lastRound ? keyed : mixCol(keyed, 1'b1);
      end else begin
        mixed = lastRound ? shifted.cols[c] : mixCol(shifted.cols[c], 1'b0);
        roundOut.cols[c] = mixed ^ roundKey.cols[c];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= sIdle;
      round <= '0;
      opReg <= opEncrypt;
      blk   <= '0;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        sIdle: if (start) begin
          blk   <= dataIn;
          opReg <= op;
          round <= 4'd1;
          state <= sInit;
        end
        // First AddRoundKey once the expander has the key
        sInit: if (keyReady) begin
          blk   <= blk ^ roundKey;
          state <= sRound;
        end
        sRound: begin
          blk   <= roundOut;
          round <= round + 4'd1;
          if (lastRound) begin
            state <= sIdle;
            done  <= 1'b1;
          end
        end
        default: state <= sIdle;
      endcase
    end
  end

  // Expander loads in the start cycle
  assign keyLoad = start && (state == sIdle);
  // No step after the last round key
  assign keyStep = ((state == sInit) && keyReady) || ((state == sRound) && !lastRound);
  assign busy    = (state != sIdle);
  assign dataOut = blk;

endmodule

/* hw/aesRegs.sv */
`timescale 1ns/100ps
`include "aes_config.svh"

module aesRegs import aesRegsPkg::*; import aesTypesPkg::*; (
  input  logic                     clk,
  input  logic                     reset,
  input  addrT                     awaddr,
  input  logic                     awvalid,
  output logic                     awready,
  input  logic [31:0]              wdata,
  input  logic [3:0]               wstrb,
  input  logic                     wvalid,
  output logic                     wready,
  output logic [1:0]               bresp,
  output logic                     bvalid,
  input  logic                     bready,
  input  addrT                     araddr,
  input  logic                     arvalid,
  output logic                     arready,
  output logic [31:0]              rdata,
  output logic [1:0]               rresp,
  output logic                     rvalid,
  input  logic                     rready,
  output logic                     start,
  output aesOpT                    op,
  output logic [`AES_KEY_BITS-1:0] key,
  output blockT                    dataIn,
  input  logic                     busy,
  input  logic                     done,
  input  blockT                    dataOut
);

  // Word 0 is the top of the key
  logic [0:3][31:0] keyWords;
  blockT       dinReg;
  // Result captured on done
  blockT       doutReg;
  aesOpT       opReg;
  logic        startReg;
  // Set by done and cleared by the next start
  logic        doneSticky;
  logic        wrAccept;
  logic        rdAccept;
  logic        wrEn;
  logic        rdEn;
  regSelT      wrSel;
  regSelT      rdSel;
  ctrlT        wrCtrl;
  ctrlT        rdCtrl;
  statT        rdStat;
  logic [31:0] rdMux;

  // Address to register group
  function automatic regSelT decode(addrT a);
    addrT base;
    addrT word;
    base = {a[`AES_ADDR_BITS-1:4], 4'h0};
    word = {a[`AES_ADDR_BITS-1:2], 2'b00};
    if (base == `AES_KEY_BASE) return selKey;
    else if (base == `AES_DIN_BASE) return selDin;
    else if (base == `AES_DOUT_BASE) return selDout;
    else if (word == `AES_CTRL) return selCtrl;
    else if (word == `AES_STAT) return selStat;
    else return selNone;
  endfunction

  // Both channels together and nothing pending
  assign wrAccept = awvalid && wvalid && !awready && !bvalid;
  assign rdAccept = arvalid && !arready && !rvalid;
  assign wrEn     = awready && awvalid && wvalid;
  assign rdEn     = arready && arvalid;
  assign wrSel    = decode(awaddr);
  assign rdSel    = decode(araddr);
  assign wrCtrl   = ctrlT'(wdata);

  // Start always reads back as zero
  assign rdCtrl = '{rsvd: '0, op: opReg, start: 1'b0};
  assign rdStat = '{rsvd: '0, done: doneSticky, busy: busy};

  always_comb begin
    case (rdSel)
      selKey:  rdMux = keyWords[araddr[3:2]];
      selDin:  rdMux = dinReg.cols[araddr[3:2]];
      selDout: rdMux = doutReg.cols[araddr[3:2]];
      selCtrl: rdMux = rdCtrl;
      selStat: rdMux = rdStat;
      default: rdMux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      awready    <= 1'b0;
      wready     <= 1'b0;
      bvalid     <= 1'b0;
      arready    <= 1'b0;
      rvalid     <= 1'b0;
      rdata      <= '0;
      keyWords   <= '0;
      dinReg     <= '0;
      doutReg    <= '0;
      opReg      <= opEncrypt;
      startReg   <= 1'b0;
      doneSticky <= 1'b0;
    end else begin
      awready <= wrAccept;
      wready  <= wrAccept;
      arready <= rdAccept;
      // Response held until taken
      if (wrEn) bvalid <= 1'b1;
      else if (bready) bvalid <= 1'b0;
      if (rdEn) begin
        rvalid <= 1'b1;
        rdata  <= rdMux;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
      // Start while busy is dropped
      startReg <= wrEn && (wrSel == selCtrl) && wrCtrl.start && !busy;
      if (wrEn) begin
        case (wrSel)
          selKey:  keyWords[awaddr[3:2]] <= wdata;
          selDin:  dinReg.cols[awaddr[3:2]] <= wdata;
          selCtrl: opReg <= wrCtrl.op;
          default: ;
        endcase
      end
      if (done) begin
        doneSticky <= 1'b1;
        doutReg    <= dataOut;
      end else if (startReg) begin
        doneSticky <= 1'b0;
      end
    end
  end

  assign bresp  = 2'b00;
  assign rresp  = 2'b00;
  assign start  = startReg;
  assign op     = opReg;
  assign key    = keyWords;
  assign dataIn = dinReg;

endmodule

/* hw/aesCore.sv */
`timescale 1ns/100ps
`include "aes_config.svh"

module aesCore import aesRegsPkg::*; import aesTypesPkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  addrT        awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  addrT        araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready
);

  // Register block to engine
  logic                     start;
  aesOpT                    op;
  logic [`AES_KEY_BITS-1:0] key;
  blockT                    dataIn;
  // Engine back to registers
  logic                     busy;
  logic                     done;
  blockT                    dataOut;
  // Engine and key expander
  blockT                    roundKey;
  logic                     keyReady;
  logic                     keyLoad;
  logic                     keyStep;

  aesRegs i_regs (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .start, .op, .key, .dataIn, .busy, .done, .dataOut
  );

  aesRound i_round (
    .clk, .reset, .start, .op, .dataIn, .roundKey, .keyReady,
    .keyLoad, .keyStep, .busy, .done, .dataOut
  );

  // Expander takes the op from the control register at load
  keyExpand i_keyExpand (
    .clk, .reset,
    .load     (keyLoad),
    .step     (keyStep),
    .op,
    .key,
    .roundKey,
    .ready    (keyReady)
  );

endmodule

/* sim/aes_assertions.sv */
`timescale 1ns/100ps

module aesAssertions import aesRegsPkg::*; (
  input logic  clk,
  input logic  reset,
  input logic  bvalid,
  input logic  bready,
  input logic  rvalid,
  input logic  rready,
  input logic  start,
  input aesOpT op,
  input logic  busy,
  input logic  done
);

  // Number of failed checks
  int failCount = 0;

  // Write response held until the host takes it
  bHold: assert property (@(posedge clk) disable iff (reset)
    bvalid && !bready |=> bvalid)
    else begin
      $error("bvalid dropped before bready");
      failCount++;
    end

  // Read data held the same way
  rHold: assert property (@(posedge clk) disable iff (reset)
    rvalid && !rready |=> rvalid)
    else begin
      $error("rvalid dropped before rready");
      failCount++;
    end

  // Single-cycle done
  donePulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else begin
      $error("done high for more than one cycle");
      failCount++;
    end

  // Engine idle once reset is released
  idleAfterReset: assert property (@(posedge clk)
    reset |=> !busy)
    else begin
      $error("busy high right after reset");
      failCount++;
    end

  // Key load, first key add, then ten rounds
  encLatency: assert property (@(posedge clk) disable iff (reset)
    start && !busy && op == opEncrypt |-> ##12 done)
    else begin
      $error("encrypt done not 12 cycles after start");
      failCount++;
    end

endmodule

// Core nets of the same names
bind aesCore aesAssertions i_aesAssertions (
  .clk, .reset, .bvalid, .bready, .rvalid, .rready, .start, .op, .busy, .done
);

/* sim/aesTb.sv */
`timescale 1ns/100ps
`include "aes_config.svh"

module aesTb import aesRegsPkg::*; ();

  // 44 cipher operations, each under 100 cycles of AXI traffic and rounds
  localparam int opCount   = 44;
  localparam int maxCycles = opCount * 100;
  // Decrypt needs 23 cycles, polling adds a few reads
  localparam int pollLimit = 100;
  // Hole in the register map
  localparam addrT holeAddr0 = 6'h38;
  localparam addrT holeAddr1 = 6'h3c;

  logic         clk = 1'b0;
  logic         reset;
  addrT         awaddr;
  logic         awvalid;
  logic         awready;
  logic [31:0]  wdata;
  logic [3:0]   wstrb;
  logic         wvalid;
  logic         wready;
  logic [1:0]   bresp;
  logic         bvalid;
  logic         bready;
  addrT         araddr;
  logic         arvalid;
  logic         arready;
  logic [31:0]  rdata;
  logic [1:0]   rresp;
  logic         rvalid;
  logic         rready;
  int           seed = 32'h494f_8304;
  int           cycles = 0;
  int           pushed = 0;
  int           checks = 0;
  int           errors = 0;
  int           baseChecks = 0;
  int           baseErrors = 0;
  // Pending comparisons, in push order
  logic [127:0] wantQ[$];
  logic [127:0] gotQ[$];
  string        nameQ[$];

  aesCore i_aesCore (.*);

  always #4 clk = ~clk;

  // Run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= maxCycles) begin
      $display("Run stopped after %0d cycles without reaching the end", maxCycles);
      $display("Regression failed");
      $finish;
    end
  end

  // GF(2^8) product by shift and add
  function automatic logic [7:0] gmul(logic [7:0] a, logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    logic [7:0] y;
    p = 8'h00;
    x = a;
    y = b;
    while (y != 8'h00) begin
      if (y[0]) begin
        p = p ^ x;
      end
      x = x[7] ? ((x << 1) ^ 8'h1b) : (x << 1);
      y = y >> 1;
    end
    return p;
  endfunction

  // Inverse by search, zero stays zero
  function automatic logic [7:0] ginv(logic [7:0] a);
    logic [7:0] r;
    r = 8'h00;
    for (int i = 1; i < 256; i++) begin
      if (gmul(a, 8'(i)) == 8'h01) begin
        r = 8'(i);
      end
    end
    return r;
  endfunction

  // S-box from the bitwise affine equations of FIPS-197
  function automatic logic [7:0] sbox(logic [7:0] x, logic inv);
    logic [7:0] a;
    logic [7:0] b;
    logic [7:0] c;
    if (inv) begin
      c = 8'h05;
      for (int i = 0; i < 8; i++) begin
        a[i] = x[(i + 2) % 8] ^ x[(i + 5) % 8] ^ x[(i + 7) % 8] ^ c[i];
      end
      b = ginv(a);
    end else begin
      c = 8'h63;
      a = ginv(x);
      for (int i = 0; i < 8; i++) begin
        b[i] = a[i] ^ a[(i + 4) % 8] ^ a[(i + 5) % 8] ^ a[(i + 6) % 8] ^
               a[(i + 7) % 8] ^ c[i];
      end
    end
    return b;
  endfunction

  // Row i takes coef[j] times byte i+j
  function automatic logic [31:0] mixColumn(logic [31:0] col, logic inv);
    logic [7:0]  coef[4];
    logic [7:0]  acc;
    logic [31:0] res;
    if (inv) begin
      coef = '{8'h0e, 8'h0b, 8'h0d, 8'h09};
    end else begin
      coef = '{8'h02, 8'h03, 8'h01, 8'h01};
    end
    res = '0;
    for (int i = 0; i < 4; i++) begin
      acc = 8'h00;
      for (int j = 0; j < 4; j++) begin
        acc = acc ^ gmul(col[31 - 8 * ((i + j) % 4) -: 8], coef[j]);
      end
      res[31 - 8 * i -: 8] = acc;
    end
    return res;
  endfunction

  // Reference AES-128, cipher or inverse cipher
  function automatic logic [127:0] aesRef(logic [127:0] key, logic [127:0] data, logic dec);
    logic [31:0]  w[44];
    logic [127:0] rk[11];
    logic [31:0]  t;
    logic [7:0]   rc;
    logic [7:0]   s[16];
    logic [7:0]   u[16];
    logic [127:0] res;
    int           r;
    // Whole key schedule up front
    rc = 8'h01;
    for (int i = 0; i < 4; i++) begin
      w[i] = key[127 - 32 * i -: 32];
    end
    for (int i = 4; i < 44; i++) begin
      t = w[i - 1];
      if (i % 4 == 0) begin
        t = {sbox(t[23:16], 1'b0), sbox(t[15:8], 1'b0), sbox(t[7:0], 1'b0),
             sbox(t[31:24], 1'b0)} ^ {rc, 24'h000000};
        rc = gmul(rc, 8'h02);
      end
      w[i] = w[i - 4] ^ t;
    end
    for (int i = 0; i < 11; i++) begin
      rk[i] = {w[4 * i], w[4 * i + 1], w[4 * i + 2], w[4 * i + 3]};
    end
    // Byte n is row n%4 of column n/4
    for (int n = 0; n < 16; n++) begin
      s[n] = data[127 - 8 * n -: 8] ^ rk[dec ? 10 : 0][127 - 8 * n -: 8];
    end
    for (int k = 1; k <= 10; k++) begin
      r = dec ? 10 - k : k;
      for (int n = 0; n < 16; n++) begin
        u[n] = sbox(s[n], dec);
      end
      for (int c = 0; c < 4; c++) begin
        for (int row = 0; row < 4; row++) begin
          // Left shift to encrypt, right shift to decrypt
          s[4 * c + row] = dec ? u[4 * ((c + 4 - row) % 4) + row] :
                                 u[4 * ((c + row) % 4) + row];
        end
      end
      for (int c = 0; c < 4; c++) begin
        t = {s[4 * c], s[4 * c + 1], s[4 * c + 2], s[4 * c + 3]};
        if (!dec && r < 10) begin
          t = mixColumn(t, 1'b0);
        end
        t = t ^ rk[r][127 - 32 * c -: 32];
        // Inverse mixing comes after the key add
        if (dec && r > 0) begin
          t = mixColumn(t, 1'b1);
        end
        for (int i = 0; i < 4; i++) begin
          s[4 * c + i] = t[31 - 8 * i -: 8];
        end
      end
    end
    for (int n = 0; n < 16; n++) begin
      res[127 - 8 * n -: 8] = s[n];
    end
    return res;
  endfunction

  task automatic randBlock(output logic [127:0] v);
    v = {$random(seed), $random(seed), $random(seed), $random(seed)};
  endtask

  // Hand a result to the comparing process
  task automatic queueCheck(input string name, input logic [127:0] want,
                            input logic [127:0] got);
    nameQ.push_back(name);
    wantQ.push_back(want);
    gotQ.push_back(got);
    pushed++;
  endtask

  task automatic axiWrite(input addrT addr, input logic [31:0] data);
    @(posedge clk);
    awaddr  <= addr;
    awvalid <= 1'b1;
    wdata   <= data;
    wvalid  <= 1'b1;
    do @(posedge clk); while (!awready);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    bready  <= 1'b1;
    do @(posedge clk); while (!bvalid);
    // Response is always OKAY
    queueCheck("bresp", 128'h0, 128'(bresp));
    bready <= 1'b0;
  endtask

  task automatic axiRead(input addrT addr, output logic [31:0] data);
    @(posedge clk);
    araddr  <= addr;
    arvalid <= 1'b1;
    do @(posedge clk); while (!arready);
    arvalid <= 1'b0;
    rready  <= 1'b1;
    do @(posedge clk); while (!rvalid);
    data = rdata;
    queueCheck("rresp", 128'h0, 128'(rresp));
    rready <= 1'b0;
  endtask

  // Word 0 carries the top 32 bits
  task automatic writeBlock(input addrT base, input logic [127:0] v);
    for (int i = 0; i < 4; i++) begin
      axiWrite(base + addrT'(4 * i), v[127 - 32 * i -: 32]);
    end
  endtask

  task automatic readBlock(input addrT base, output logic [127:0] v);
    logic [31:0] word;
    for (int i = 0; i < 4; i++) begin
      axiRead(base + addrT'(4 * i), word);
      v[127 - 32 * i -: 32] = word;
    end
  endtask

  task automatic waitDone();
    logic [31:0] stat;
    int          t0;
    t0 = cycles;
    stat = '0;
    while (!stat[1] && (cycles - t0 <= pollLimit)) begin
      axiRead(`AES_STAT, stat);
    end
    assert (stat[1]) else begin
      $display("Status never showed done within %0d cycles", pollLimit);
      errors++;
    end
  endtask

  task automatic runOp(input logic [127:0] key, input logic [127:0] din, input aesOpT op,
                       input logic loadKey, output logic [127:0] dout);
    if (loadKey) begin
      writeBlock(`AES_KEY_BASE, key);
    end
    writeBlock(`AES_DIN_BASE, din);
    axiWrite(`AES_CTRL, {30'd0, op, 1'b1});
    waitDone();
    readBlock(`AES_DOUT_BASE, dout);
  endtask

  // One line per test once its checks are through
  task automatic finishTest(input string name);
    while (checks != pushed) @(negedge clk);
    $display("Test %s: %0d checks, %0d errors", name, checks - baseChecks,
             errors - baseErrors);
    baseChecks = checks;
    baseErrors = errors;
  endtask

  // Comparing process
  initial begin
    logic [127:0] want;
    logic [127:0] got;
    string        name;
    forever begin
      @(posedge clk);
      while (gotQ.size() != 0) begin
        name = nameQ.pop_front();
        want = wantQ.pop_front();
        got  = gotQ.pop_front();
        checks++;
        assert (got === want) else begin
          $display("Error %s: expected 0x%0h, got 0x%0h", name, want, got);
          errors++;
        end
      end
    end
  end

  // Stimulus
  initial begin
    logic [127:0] key;
    logic [127:0] din;
    logic [127:0] ct;
    logic [127:0] pt;
    logic [31:0]  word;
    reset   = 1'b1;
    awaddr  = '0;
    awvalid = 1'b0;
    wdata   = '0;
    wstrb   = 4'hf;
    wvalid  = 1'b0;
    bready  = 1'b0;
    araddr  = '0;
    arvalid = 1'b0;
    rready  = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    // FIPS-197 appendix C.1
    key = 128'h000102030405060708090a0b0c0d0e0f;
    din = 128'h00112233445566778899aabbccddeeff;
    runOp(key, din, opEncrypt, 1'b1, ct);
    queueCheck("dout", aesRef(key, din, 1'b0), ct);
    queueCheck("dout", 128'h69c4e0d86a7b0430d8cdb78070b4c55a, ct);
    finishTest("fips encrypt");

    // Same key is still loaded
    runOp(key, 128'h69c4e0d86a7b0430d8cdb78070b4c55a, opDecrypt, 1'b0, pt);
    queueCheck("dout", din, pt);
    finishTest("fips decrypt");

    // Random round trips
    for (int n = 0; n < 20; n++) begin
      randBlock(key);
      randBlock(din);
      runOp(key, din, opEncrypt, 1'b1, ct);
      queueCheck("dout", aesRef(key, din, 1'b0), ct);
      runOp(key, ct, opDecrypt, 1'b0, pt);
      queueCheck("dout", din, pt);
    end
    finishTest("random round trip");

    // Register readback and status
    randBlock(key);
    randBlock(din);
    writeBlock(`AES_KEY_BASE, key);
    writeBlock(`AES_DIN_BASE, din);
    for (int i = 0; i < 4; i++) begin
      axiRead(`AES_KEY_BASE + addrT'(4 * i), word);
      queueCheck("key", 128'(key[127 - 32 * i -: 32]), 128'(word));
      axiRead(`AES_DIN_BASE + addrT'(4 * i), word);
      queueCheck("din", 128'(din[127 - 32 * i -: 32]), 128'(word));
    end
    axiRead(holeAddr0, word);
    queueCheck("rdata", 128'h0, 128'(word));
    axiRead(holeAddr1, word);
    queueCheck("rdata", 128'h0, 128'(word));
    axiWrite(`AES_CTRL, {30'd0, opEncrypt, 1'b1});
    // Busy set, done cleared by the new start
    axiRead(`AES_STAT, word);
    queueCheck("stat", 128'h1, 128'(word));
    waitDone();
    axiRead(`AES_STAT, word);
    queueCheck("stat", 128'h2, 128'(word));
    readBlock(`AES_DOUT_BASE, ct);
    queueCheck("dout", aesRef(key, din, 1'b0), ct);
    finishTest("register readback");

    // Decrypt leaves a long busy window
    randBlock(key);
    randBlock(din);
    writeBlock(`AES_KEY_BASE, key);
    writeBlock(`AES_DIN_BASE, din);
    axiWrite(`AES_CTRL, {30'd0, opDecrypt, 1'b1});
    // New input and a second start while the engine runs
    axiWrite(`AES_DIN_BASE, ~din[127:96]);
    axiWrite(`AES_CTRL, {30'd0, opDecrypt, 1'b1});
    waitDone();
    readBlock(`AES_DOUT_BASE, pt);
    queueCheck("dout", aesRef(key, din, 1'b1), pt);
    finishTest("start while busy");

    // Bound assertion failures count as errors
    if (i_aesCore.i_aesAssertions.failCount != 0) begin
      $display("Bound assertions failed %0d times", i_aesCore.i_aesAssertions.failCount);
      errors += i_aesCore.i_aesAssertions.failCount;
    end
    $display("Checks %0d, errors %0d, cycles %0d", checks, errors, cycles);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+hw
hw/aesTypesPkg.sv
hw/aesRegsPkg.sv
hw/aesSbox.sv
hw/keyExpand.sv
hw/aesRound.sv
hw/aesRegs.sv
hw/aesCore.sv
sim/aes_assertions.sv
sim/aesTb.sv

/* Makefile */
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f verilog.f --top-module aesTb -Mdir obj_dir -o aesTb

run: build
	./obj_dir/aesTb > $(LOG) 2>&1 || (cat $(LOG); exit 1)
	cat $(LOG)
	! grep -q "Regression failed" $(LOG)

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module aesTb

clean:
	rm -rf obj_dir $(LOG)
